// File: hw/aes_pkg.sv
package aes_pkg;

    typedef logic [127:0] block_t; // byte 0 sits in bits 127:120.
    typedef logic [31:0]  word_t;

    localparam int NUM_ROUNDS     = 10;
    localparam int NUM_ROUND_KEYS = NUM_ROUNDS + 1;

    typedef logic [3:0] rk_addr_t;

    // one request into the round-key store.
    typedef struct packed {
        logic     req;
        logic     write;
        rk_addr_t addr;
        block_t   data;
    } key_access_t;

    typedef enum logic [1:0] {
        MODE_HOLD,
        MODE_LOAD,  // plaintext xor round key 0.
        MODE_FULL,
        MODE_FINAL  // last round skips MixColumns.
    } round_mode_e;

    localparam logic [7:0] SBOX [256] = '{
        8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5,
        8'h30, 8'h01, 8'h67, 8'h2b, 8'hfe, 8'hd7, 8'hab, 8'h76,
        8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0,
        8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0,
        8'hb7, 8'hfd, 8'h93, 8'h26, 8'h36, 8'h3f, 8'hf7, 8'hcc,
        8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15,
        8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a,
        8'h07, 8'h12, 8'h80, 8'he2, 8'heb, 8'h27, 8'hb2, 8'h75,
        8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0,
        8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84,
        8'h53, 8'hd1, 8'h00, 8'hed, 8'h20, 8'hfc, 8'hb1, 8'h5b,
        8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf,
        8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85,
        8'h45, 8'hf9, 8'h02, 8'h7f, 8'h50, 8'h3c, 8'h9f, 8'ha8,
        8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5,
        8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2,
        8'hcd, 8'h0c, 8'h13, 8'hec, 8'h5f, 8'h97, 8'h44, 8'h17,
        8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73,
        8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88,
        8'h46, 8'hee, 8'hb8, 8'h14, 8'hde, 8'h5e, 8'h0b, 8'hdb,
        8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c,
        8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79,
        8'he7, 8'hc8, 8'h37, 8'h6d, 8'h8d, 8'hd5, 8'h4e, 8'ha9,
        8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08,
        8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6,
        8'he8, 8'hdd, 8'h74, 8'h1f, 8'h4b, 8'hbd, 8'h8b, 8'h8a,
        8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e,
        8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e,
        8'he1, 8'hf8, 8'h98, 8'h11, 8'h69, 8'hd9, 8'h8e, 8'h94,
        8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf,
        8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68,
        8'h41, 8'h99, 8'h2d, 8'h0f, 8'hb0, 8'h54, 8'hbb, 8'h16
    };

    function automatic logic [7:0] sub_byte(logic [7:0] b);
        return SBOX[b];
    endfunction

    // multiply by 2 in GF(2^8), reducing by the AES polynomial.
    function automatic logic [7:0] xtime(logic [7:0] b);
        return b[7] ? ({b[6:0], 1'b0} ^ 8'h1b) : {b[6:0], 1'b0};
    endfunction

    function automatic word_t sub_word(word_t w);
        return {sub_byte(w[31:24]), sub_byte(w[23:16]), sub_byte(w[15:8]), sub_byte(w[7:0])};
    endfunction

    function automatic word_t rot_word(word_t w);
        return {w[23:0], w[31:24]};
    endfunction

endpackage

// File: hw/key_expander.sv
module key_expander
    import aes_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        key_start,
    input  logic        enc_ready,
    input  block_t      key,
    output logic        key_ready,
    output logic        key_free,
    output key_access_t key_req
);

    logic       busy;
    rk_addr_t   round;
    block_t     work;      // previous round key.
    logic [7:0] rcon;
    logic       accept;
    word_t      temp;
    word_t      w0;
    word_t      w1;
    word_t      w2;
    word_t      w3;

    assign key_ready = !busy;
    assign key_free  = key_ready && !key_start;
    assign accept    = key_start && key_ready && enc_ready; // never restart under encryption.

    always_comb
    begin
        temp = sub_word(rot_word(work[31:0])) ^ {rcon, 24'h000000};
        w0   = work[127:96] ^ temp;
        w1   = work[95:64] ^ w0;
        w2   = work[63:32] ^ w1;
        w3   = work[31:0] ^ w2;
    end

    always_comb
    begin
        key_req = '0;
        if (accept)
        begin
            key_req.req   = 1'b1;
            key_req.write = 1'b1;
            key_req.addr  = '0;
            key_req.data  = key; // round key 0 is the cipher key itself.
        end
        else if (busy)
        begin
            key_req.req   = 1'b1;
            key_req.write = 1'b1;
            key_req.addr  = round;
            key_req.data  = {w0, w1, w2, w3};
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            busy  <= 1'b0;
            round <= '0;
            rcon  <= 8'h01;
        end
        else if (accept)
        begin
            busy  <= 1'b1;
            round <= rk_addr_t'(1);
            rcon  <= 8'h01;
        end
        else if (busy)
        begin
            round <= round + rk_addr_t'(1);
            rcon  <= xtime(rcon);
            if (round == rk_addr_t'(NUM_ROUNDS))
                busy <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
            work <= key;
        else if (busy)
            work <= {w0, w1, w2, w3};
    end

endmodule

// File: hw/round_key_store.sv
module round_key_store
    import aes_pkg::*;
(
    input  logic        clk,
    input  key_access_t key_req,
    input  key_access_t cipher_req,
    output block_t      round_key
);

    block_t      mem [NUM_ROUND_KEYS];
    key_access_t grant;

    // the key expander always wins the shared port.
    always_comb
    begin
        if (key_req.req)
            grant = key_req;
        else
            grant = cipher_req;
    end

    always_ff @(posedge clk)
    begin
        if (grant.req && grant.write)
            mem[grant.addr] <= grant.data;
    end

    assign round_key = mem[grant.addr]; // read is combinational on the granted address.

endmodule

// File: hw/cipher_control.sv
module cipher_control
    import aes_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        enc_start,
    input  logic        key_free,
    output logic        enc_ready,
    output key_access_t cipher_req,
    output round_mode_e mode
);

    logic     busy;
    rk_addr_t round;
    logic     accept;

    assign enc_ready = !busy;
    assign accept    = enc_start && key_free && enc_ready;

    always_comb
    begin
        cipher_req       = '0;
        cipher_req.req   = accept || busy;
        cipher_req.write = 1'b0;
        cipher_req.addr  = accept ? rk_addr_t'(0) : round;
    end

    always_comb
    begin
        if (accept)
            mode = MODE_LOAD;
        else if (busy && round == rk_addr_t'(NUM_ROUNDS))
            mode = MODE_FINAL;
        else if (busy)
            mode = MODE_FULL;
        else
            mode = MODE_HOLD;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            busy  <= 1'b0;
            round <= '0;
        end
        else if (accept)
        begin
            busy  <= 1'b1;
            round <= rk_addr_t'(1);
        end
        else if (busy)
        begin
            round <= round + rk_addr_t'(1);
            if (round == rk_addr_t'(NUM_ROUNDS))
                busy <= 1'b0; // ciphertext is in the state register from the next cycle.
        end
    end

endmodule

// File: hw/cipher_datapath.sv
module cipher_datapath
    import aes_pkg::*;
(
    input  logic        clk,
    input  round_mode_e mode,
    input  block_t      plaintext,
    input  block_t      round_key,
    output block_t      ciphertext
);

    block_t state;
    block_t shifted;
    block_t mixed;

    function automatic word_t mix_column(word_t col);
        logic [7:0] a0;
        logic [7:0] a1;
        logic [7:0] a2;
        logic [7:0] a3;
        a0 = col[31:24];
        a1 = col[23:16];
        a2 = col[15:8];
        a3 = col[7:0];
        return {xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3,
                a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3,
                a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3,
                xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3)};
    endfunction

    // SubBytes followed by ShiftRows. Row r of column c comes from column c + r.
    always_comb
    begin
        for (int c = 0; c < 4; c++)
        begin
            for (int r = 0; r < 4; r++)
                shifted[127 - 8 * (4 * c + r) -: 8] =
                    sub_byte(state[127 - 8 * (4 * ((c + r) % 4) + r) -: 8]);
        end
    end

    always_comb
    begin
        for (int c = 0; c < 4; c++)
            mixed[127 - 32 * c -: 32] = mix_column(shifted[127 - 32 * c -: 32]);
    end

    always_ff @(posedge clk)
    begin
        case (mode)
            MODE_LOAD:  state <= plaintext ^ round_key;
            MODE_FULL:  state <= mixed ^ round_key;
            MODE_FINAL: state <= shifted ^ round_key;
            default:    state <= state;
        endcase
    end

    assign ciphertext = state;

endmodule

// File: hw/aes_core.sv
module aes_core
    import aes_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   key_start,
    input  logic   enc_start,
    input  block_t key,
    input  block_t plaintext,
    output logic   key_ready,
    output logic   enc_ready,
    output block_t ciphertext
);

    key_access_t key_req;
    key_access_t cipher_req;
    logic        key_free;
    block_t      round_key;
    round_mode_e mode;

    key_expander u_key_expander (
        .clk       (clk),
        .rst       (rst),
        .key_start (key_start),
        .enc_ready (enc_ready),
        .key       (key),
        .key_ready (key_ready),
        .key_free  (key_free),
        .key_req   (key_req)
    );

    // both engines share this store and the expander has priority.
    round_key_store u_round_key_store (
        .clk        (clk),
        .key_req    (key_req),
        .cipher_req (cipher_req),
        .round_key  (round_key)
    );

    cipher_control u_cipher_control (
        .clk        (clk),
        .rst        (rst),
        .enc_start  (enc_start),
        .key_free   (key_free),
        .enc_ready  (enc_ready),
        .cipher_req (cipher_req),
        .mode       (mode)
    );

    cipher_datapath u_cipher_datapath (
        .clk        (clk),
        .mode       (mode),
        .plaintext  (plaintext),
        .round_key  (round_key),
        .ciphertext (ciphertext)
    );

endmodule

// File: testbench/tb_aes_core.sv
module tb_aes_core
    import aes_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam block_t FIPS_KEY = 128'h000102030405060708090a0b0c0d0e0f;
    localparam block_t FIPS_PT  = 128'h00112233445566778899aabbccddeeff;
    localparam block_t FIPS_CT  = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;

    logic        clk;
    logic        rst;
    logic        key_start;
    logic        enc_start;
    block_t      key;
    block_t      plaintext;
    logic        key_ready;
    logic        enc_ready;
    block_t      ciphertext;
    logic [31:0] lfsr;
    block_t      current_key;
    block_t      expected_q [$];
    int          checks;
    int          errors;

    aes_core UUT (
        .clk        (clk),
        .rst        (rst),
        .key_start  (key_start),
        .enc_start  (enc_start),
        .key        (key),
        .plaintext  (plaintext),
        .key_ready  (key_ready),
        .enc_ready  (enc_ready),
        .ciphertext (ciphertext)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // taps 32, 22, 2 and 1.
    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_block(output block_t b);
        b = '0;
        for (int i = 0; i < 128; i++)
        begin
            lfsr = lfsr_step(lfsr);
            b    = {b[126:0], lfsr[0]};
        end
    endtask

    // bytes are kept in FIPS-197 order and s[r + 4c] is row r of column c.
    function automatic block_t aes_encrypt(block_t k, block_t p);
        word_t      w [44];
        logic [7:0] s [16];
        logic [7:0] t [16];
        logic [7:0] a [4];
        logic [7:0] all;
        logic [7:0] rc;
        block_t     result;
        rc = 8'h01;
        for (int i = 0; i < 4; i++)
            w[i] = k[127 - 32 * i -: 32];
        for (int i = 4; i < 44; i++)
        begin
            if (i % 4 == 0)
            begin
                w[i] = w[i - 4] ^ sub_word(rot_word(w[i - 1])) ^ {rc, 24'h000000};
                rc   = xtime(rc);
            end
            else
                w[i] = w[i - 4] ^ w[i - 1];
        end
        for (int n = 0; n < 16; n++)
            s[n] = p[127 - 8 * n -: 8] ^ w[n / 4][31 - 8 * (n % 4) -: 8];
        for (int rnd = 1; rnd <= 10; rnd++)
        begin
            for (int n = 0; n < 16; n++)
                t[n] = sub_byte(s[n]);
            for (int c = 0; c < 4; c++)
            begin
                for (int r = 0; r < 4; r++)
                    s[r + 4 * c] = t[r + 4 * ((c + r) % 4)];
            end
            if (rnd < 10)
            begin
                for (int c = 0; c < 4; c++)
                begin
                    for (int j = 0; j < 4; j++)
                        a[j] = s[4 * c + j];
                    all = a[0] ^ a[1] ^ a[2] ^ a[3];
                    for (int j = 0; j < 4; j++)
                        s[4 * c + j] = a[j] ^ all ^ xtime(a[j] ^ a[(j + 1) % 4]);
                end
            end
            for (int n = 0; n < 16; n++)
                s[n] = s[n] ^ w[4 * rnd + n / 4][31 - 8 * (n % 4) -: 8];
        end
        for (int n = 0; n < 16; n++)
            result[127 - 8 * n -: 8] = s[n];
        return result;
    endfunction

    task automatic abort_run(input string what);
        errors++;
        $display("%s", what);
        $display("checks %0d, errors %0d", checks, errors);
        $display("sim failed");
        $finish;
    endtask

    task automatic wait_ready();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!(key_ready && enc_ready) && cycles < 50)
        begin
            @(negedge clk);
            cycles++;
        end
        if (!(key_ready && enc_ready))
            abort_run("timed out waiting for key_ready and enc_ready to rise");
    endtask

    // holds the strobes for exactly one clock.
    task automatic strobe_inputs(block_t k, block_t p, logic ks, logic es);
        @(posedge clk);
        #1;
        key       = k;
        plaintext = p;
        key_start = ks;
        enc_start = es;
        @(posedge clk);
        #1;
        key_start = 1'b0;
        enc_start = 1'b0;
    endtask

    task automatic load_key(block_t k);
        wait_ready();
        strobe_inputs(k, plaintext, 1'b1, 1'b0);
        current_key = k;
    endtask

    task automatic encrypt_block(block_t p);
        wait_ready();
        expected_q.push_back(aes_encrypt(current_key, p));
        strobe_inputs(key, p, 1'b0, 1'b1);
        wait_ready();
    endtask

    // the comparison process checks every finished expansion and encryption.
    initial
    begin
        int     key_low;
        int     enc_low;
        block_t expected;
        key_low = 0;
        enc_low = 0;
        forever
        begin
            @(negedge clk);
            if (!rst)
            begin
                if (!key_ready)
                    key_low++;
                else if (key_low != 0)
                begin
                    checks++;
                    if (key_low != 10)
                    begin
                        errors++;
                        $display("error: key_ready low for %0h cycles, expected a", key_low);
                    end
                    key_low = 0;
                end
                if (!enc_ready)
                    enc_low++;
                else if (enc_low != 0)
                begin
                    checks++;
                    if (enc_low != 10)
                    begin
                        errors++;
                        $display("error: enc_ready low for %0h cycles, expected a", enc_low);
                    end
                    enc_low = 0;
                    if (expected_q.size() == 0)
                    begin
                        errors++;
                        $display("an encryption finished that the testbench never started");
                    end
                    else
                    begin
                        expected = expected_q.pop_front();
                        if (ciphertext !== expected)
                        begin
                            errors++;
                            $display("error: ciphertext = %h, expected %h", ciphertext, expected);
                        end
                    end
                end
            end
        end
    end

    initial
    begin
        block_t k;
        block_t p;
        block_t held;
        rst         = 1'b1;
        key_start   = 1'b0;
        enc_start   = 1'b0;
        key         = '0;
        plaintext   = '0;
        current_key = '0;
        lfsr        = 32'h9c83_3ebf;
        checks      = 0;
        errors      = 0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        checks++;
        if (key_ready !== 1'b1 || enc_ready !== 1'b1)
        begin
            errors++;
            $display("error: key_ready = %h, enc_ready = %h after reset, expected 1", key_ready,
                     enc_ready);
        end

        checks++;
        if (aes_encrypt(FIPS_KEY, FIPS_PT) !== FIPS_CT)
        begin
            errors++;
            $display("error: model ciphertext = %h, expected %h", aes_encrypt(FIPS_KEY, FIPS_PT),
                     FIPS_CT);
        end
        load_key(FIPS_KEY);
        encrypt_block(FIPS_PT);
        checks++;
        if (ciphertext !== FIPS_CT)
        begin
            errors++;
            $display("error: ciphertext = %h, expected %h", ciphertext, FIPS_CT);
        end

        repeat (10)
        begin
            random_block(k);
            random_block(p);
            load_key(k);
            encrypt_block(p);
        end

        random_block(k);
        load_key(k);
        repeat (4)
        begin
            random_block(p);
            encrypt_block(p);
        end
        held = ciphertext;
        repeat (8) @(negedge clk);
        checks++;
        if (ciphertext !== held)
        begin
            errors++;
            $display("error: idle ciphertext = %h, expected %h", ciphertext, held);
        end

        // enc_start in the cycle after a key load lands while the expander is busy.
        random_block(k);
        random_block(p);
        load_key(k);
        strobe_inputs(k, p, 1'b0, 1'b1);
        random_block(p);
        encrypt_block(p);

        random_block(p);
        wait_ready();
        expected_q.push_back(aes_encrypt(current_key, p));
        strobe_inputs(key, p, 1'b0, 1'b1);
        random_block(k);
        strobe_inputs(k, p, 1'b1, 1'b0);
        @(negedge clk);
        checks++;
        if (key_ready !== 1'b1)
        begin
            errors++;
            $display("error: key_ready = %h during encryption, expected 1", key_ready);
        end
        random_block(p);
        encrypt_block(p);

        random_block(k);
        random_block(p);
        wait_ready();
        strobe_inputs(k, p, 1'b1, 1'b1);
        current_key = k;
        @(negedge clk);
        checks++;
        if (enc_ready !== 1'b1 || key_ready !== 1'b0)
        begin
            errors++;
            $display("error: enc_ready = %h, key_ready = %h, expected 1 and 0", enc_ready,
                     key_ready);
        end
        encrypt_block(p);

        repeat (3) @(negedge clk);
        checks++;
        if (expected_q.size() != 0)
        begin
            errors++;
            $display("some started encryptions never finished");
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

// File: sim.f
hw/aes_pkg.sv
hw/key_expander.sv
hw/round_key_store.sv
hw/cipher_control.sv
hw/cipher_datapath.sv
hw/aes_core.sv
testbench/tb_aes_core.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = tb_aes_core
FILELIST  = sim.f
OBJ_DIR   = obj_dir
SIM_BIN   = $(OBJ_DIR)/V$(TOP)
SOURCES   = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf $(OBJ_DIR)
